// File: bench/radio_top_assert.sv
`timescale 1ns/1ps

`include "radio_defs.svh"

// capture buffer protocol checks
module radio_top_assert (
   input logic             radio_clk,
   input logic             i_rst_n,
   input logic [`NUM_CH:0] i_gnt,       // {rb, ch1, ch0}
   input logic             i_rb_stb,
   input logic             i_rb_pend,
   input logic             i_rb_valid
);

   logic rd_open_r;  // strobe taken, its valid not seen yet

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         rd_open_r <= 1'b0;
      end else if (i_rb_stb) begin
         rd_open_r <= 1'b1;
      end else if (i_rb_valid) begin
         rd_open_r <= 1'b0;  // answered
      end
   end

   // one owner of the memory per cycle
   gnt_onehot: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $onehot0(i_gnt))
      else $error("more than one grant in one cycle: %b", i_gnt);

   // valid pulse only while a strobed read is still open
   valid_after_pend: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      i_rb_valid |-> rd_open_r)
      else $error("o_rb.valid without a pending read");

   // one read in flight at a time
   no_stb_while_pend: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      i_rb_pend |-> !i_rb_stb)
      else $error("readback strobe while a read is pending");

endmodule

bind sample_buf radio_top_assert assert_i (
   .radio_clk  (radio_clk),
   .i_rst_n    (i_rst_n),
   .i_gnt      (gnt),
   .i_rb_stb   (i_rb_stb),
   .i_rb_pend  (rb_pend_r),
   .i_rb_valid (o_rb.valid)
);

// File: bench/radio_top_tb.sv
`timescale 1ns/1ps

`include "radio_defs.svh"

module radio_top_tb;

   localparam int TBL_LEN   = 27;
   localparam int WD_CYCLES = (TBL_LEN + 64) * 10;  // watchdog budget in clocks
   localparam int RB_WAIT   = 16;                   // longest wait for one read

   // one stimulus row
   typedef struct packed {
      logic [1:0]  mask;   // bit per channel
      logic [31:0] iq;     // I high, Q low, same word to both channels
      logic [3:0]  gap;    // clocks until the next row
      logic [1:0]  ctrl0;  // {swap, run} for ch0
      logic [1:0]  ctrl1;  // {swap, run} for ch1
   } stim_t;

   logic               radio_clk;
   logic               rst_n;
   bus_pkg::set_bus_t  set_bus;
   radio_pkg::sample_u rx0;
   radio_pkg::sample_u rx1;
   logic               rx_stb0;
   logic               rx_stb1;
   logic               rb_stb;
   logic [`BUF_AW:0]   rb_addr;
   bus_pkg::rb_rsp_t   rb;
   logic [`NUM_CH-1:0] overflow;

   stim_t       tbl [TBL_LEN];
   logic [37:0] rb_q [$];            // {addr, expected word}, ready to read
   logic [15:0] dc_i_m [`NUM_CH];    // model copies of the settings
   logic [15:0] dc_q_m [`NUM_CH];
   logic [1:0]  ctrl_m [`NUM_CH];
   logic [4:0]  ptr_m [`NUM_CH];     // model write pointers
   integer      seed;
   int          err_cnt;
   int          chk_cnt;
   int          rb_sent;
   int          valid_cnt;
   logic        stim_done;

   radio_top dut_i (
      .radio_clk  (radio_clk),
      .i_rst_n    (rst_n),
      .i_set      (set_bus),
      .i_rx0      (rx0),
      .i_rx_stb0  (rx_stb0),
      .i_rx1      (rx1),
      .i_rx_stb1  (rx_stb1),
      .i_rb_stb   (rb_stb),
      .i_rb_addr  (rb_addr),
      .o_rb       (rb),
      .o_overflow (overflow)
   );

   initial radio_clk = 1'b0;
   always #20 radio_clk = ~radio_clk;  // 40 ns period

   always @(negedge radio_clk) begin
      if (rb.valid === 1'b1) valid_cnt++;  // every read pulse
   end

   ////////////////////
   // reference model
   ////////////////////
   // optional swap, then subtract the offsets mod 2^16
   function automatic logic [31:0] corr_word(input logic [31:0] w, input logic [15:0] dci,
                                             input logic [15:0] dcq, input logic sw);
      logic [15:0] a;
      logic [15:0] b;
      a = sw ? w[15:0] : w[31:16];
      b = sw ? w[31:16] : w[15:0];
      return {a - dci, b - dcq};
   endfunction

   task automatic build_table();
      int e;
      for (e = 0; e < TBL_LEN; e++) begin
         tbl[e].iq = $random(seed);
         if (e < 6) begin          // plain correction, masks 01 10 11
            tbl[e].mask  = 2'(e % 3 + 1);
            tbl[e].gap   = 4'(4 + e % 3);
            tbl[e].ctrl0 = 2'b01;
            tbl[e].ctrl1 = 2'b01;
         end else if (e < 12) begin  // ch1 swapped
            tbl[e].mask  = 2'b11;
            tbl[e].gap   = 4'd5;
            tbl[e].ctrl0 = 2'b01;
            tbl[e].ctrl1 = 2'b11;
         end else if (e < 20) begin  // both channels every 4 clocks
            tbl[e].mask  = 2'b11;
            tbl[e].gap   = 4'd4;
            tbl[e].ctrl0 = 2'b01;
            tbl[e].ctrl1 = 2'b01;
         end else if (e < 24) begin  // stopped, nothing stored
            tbl[e].mask  = 2'b11;
            tbl[e].gap   = 4'd4;
            tbl[e].ctrl0 = 2'b00;
            tbl[e].ctrl1 = 2'b00;
         end else begin             // running again
            tbl[e].mask  = 2'b11;
            tbl[e].gap   = 4'd4;
            tbl[e].ctrl0 = 2'b01;
            tbl[e].ctrl1 = 2'b01;
         end
      end
   endtask

   ////////////////////
   // drivers
   ////////////////////
   // all drivers start and end 1 ns after a rising edge
   task automatic write_set(input logic [3:0] ch, input logic [3:0] reg_sel,
                            input logic [31:0] data);
      set_bus.stb  = 1'b1;
      set_bus.addr = {ch, reg_sel};
      set_bus.data = data;
      @(posedge radio_clk);
      #1;
      set_bus.stb  = 1'b0;
   endtask

   task automatic apply_sample(input logic [1:0] mask, input logic [31:0] iq);
      rx0.raw = iq;
      rx1.raw = iq;
      rx_stb0 = mask[0];
      rx_stb1 = mask[1];
      @(posedge radio_clk);
      #1;
      rx_stb0 = 1'b0;
      rx_stb1 = 1'b0;
   endtask

   task automatic read_check(input logic [5:0] addr, input logic [31:0] exp);
      int n;
      rb_stb  = 1'b1;
      rb_addr = addr;
      @(posedge radio_clk);
      #1;
      rb_stb  = 1'b0;
      rb_sent++;
      n = 0;
      @(negedge radio_clk);
      while (rb.valid !== 1'b1 && n < RB_WAIT) begin
         @(negedge radio_clk);
         n++;
      end
      chk_cnt++;
      assert (n < RB_WAIT) else begin
         err_cnt++;
         $display("readback of address %h at %0t never returned valid", addr, $time);
      end
      if (n < RB_WAIT) begin
         chk_cnt++;
         assert (rb.data === exp) else begin
            err_cnt++;
            $display("Mismatch at %0t: o_rb.data addr %h expected %h got %h",
                     $time, addr, exp, rb.data);
         end
      end
      @(posedge radio_clk);
      #1;  // back in step with the drive phase
   endtask

   task automatic check_overflow(input logic [1:0] exp);
      @(negedge radio_clk);
      chk_cnt++;
      assert (overflow === exp) else begin
         err_cnt++;
         $display("Mismatch at %0t: o_overflow expected %b got %b", $time, exp, overflow);
      end
      @(posedge radio_clk);
      #1;
   endtask

   ////////////////////
   // sequences
   ////////////////////
   task automatic run_table();
      int          e;
      int          c;
      logic [37:0] pend [$];  // words of this row, readable after its gap
      for (e = 0; e < TBL_LEN; e++) begin
         if (tbl[e].ctrl0 != ctrl_m[0]) begin
            write_set(4'd0, `SR_CTRL, 32'(tbl[e].ctrl0));
            ctrl_m[0] = tbl[e].ctrl0;
         end
         if (tbl[e].ctrl1 != ctrl_m[1]) begin
            write_set(4'd1, `SR_CTRL, 32'(tbl[e].ctrl1));
            ctrl_m[1] = tbl[e].ctrl1;
         end
         apply_sample(tbl[e].mask, tbl[e].iq);
         for (c = 0; c < `NUM_CH; c++) begin
            if (tbl[e].mask[c] && ctrl_m[c][0]) begin  // stopped channel stores nothing
               pend.push_back({1'(c), ptr_m[c],
                               corr_word(tbl[e].iq, dc_i_m[c], dc_q_m[c], ctrl_m[c][1])});
               ptr_m[c]++;
            end
         end
         repeat (tbl[e].gap - 1) begin
            @(posedge radio_clk);
            #1;
         end
         while (pend.size() > 0) rb_q.push_back(pend.pop_front());
      end
      stim_done = 1'b1;
   endtask

   // reads run alongside capture
   task automatic drain_reads();
      logic [37:0] item;
      while (!stim_done || rb_q.size() > 0) begin
         if (rb_q.size() > 0) begin
            item = rb_q.pop_front();
            read_check(item[37:32], item[31:0]);
         end else begin
            @(posedge radio_clk);
            #1;
         end
      end
   endtask

   task automatic overflow_burst();
      int k;
      rx_stb0 = 1'b1;  // ch0 every clock, ch1 idle
      for (k = 0; k < 6; k++) begin
         rx0.raw = $random(seed);
         @(posedge radio_clk);
         #1;
      end
      rx_stb0 = 1'b0;
      repeat (4) @(posedge radio_clk);  // let the last hold drain
      #1;
   endtask

   ////////////////////
   // main
   ////////////////////
   initial begin
      int c;
      seed      = 40;
      err_cnt   = 0;
      chk_cnt   = 0;
      rb_sent   = 0;
      valid_cnt = 0;
      stim_done = 1'b0;
      rst_n     = 1'b0;
      set_bus   = '0;
      rx0       = '0;
      rx1       = '0;
      rx_stb0   = 1'b0;
      rx_stb1   = 1'b0;
      rb_stb    = 1'b0;
      rb_addr   = '0;
      for (c = 0; c < `NUM_CH; c++) begin
         ctrl_m[c] = 2'b00;  // matches reset
         ptr_m[c]  = '0;
      end
      build_table();
      repeat (10) @(posedge radio_clk);
      #1;
      rst_n = 1'b1;
      // offsets first, control comes with the table
      for (c = 0; c < `NUM_CH; c++) begin
         dc_i_m[c] = 16'($random(seed));
         dc_q_m[c] = 16'($random(seed));
         write_set(4'(c), `SR_DC_I, 32'(dc_i_m[c]));
         write_set(4'(c), `SR_DC_Q, 32'(dc_q_m[c]));
      end
      fork
         run_table();
         drain_reads();
      join
      chk_cnt++;
      assert (valid_cnt == rb_sent) else begin
         err_cnt++;
         $display("Mismatch at %0t: o_rb.valid pulses expected %0d got %0d",
                  $time, rb_sent, valid_cnt);
      end
      check_overflow(2'b00);  // paced capture never overflows
      overflow_burst();
      check_overflow(2'b01);
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      repeat (WD_CYCLES) @(posedge radio_clk);
      $display("watchdog expired after %0d clocks, test did not finish", WD_CYCLES);
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: common/bus_pkg.sv
// bus level types: settings strobes, buffer write requests, readback
package bus_pkg;

`include "radio_defs.svh"

   // settings write, plain strobe with address and data
   typedef struct packed {
      logic              stb;
      logic [`SET_AW-1:0] addr;  // [7:4] channel, [3:0] register
      logic [`SET_DW-1:0] data;
   } set_bus_t;

   // one corrected sample waiting for the buffer
   // req is a level, held until granted
   typedef struct packed {
      logic               req;
      radio_pkg::sample_u sample;
   } wr_req_t;

   // readback result, valid is a single-cycle pulse
   typedef struct packed {
      logic                 valid;
      logic [`SAMPLE_W-1:0] data;
   } rb_rsp_t;

endpackage

// File: common/radio_defs.svh
`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

// sample format
`define SAMPLE_W 32 // one I/Q word
`define IQ_W     16 // per component

// channels and capture buffer
`define NUM_CH   2
`define BUF_AW   5  // 32 words per channel, channel bit sits above

// settings bus
`define SET_AW   8
`define SET_DW   32
`define SR_REG_W 4  // low addr bits pick the register, upper bits the channel

// register offsets within a channel
`define SR_DC_I  4'd0
`define SR_DC_Q  4'd1
`define SR_CTRL  4'd2

// SR_CTRL bits
`define CTRL_RUN_BIT  0
`define CTRL_SWAP_BIT 1

`endif

// File: common/radio_pkg.sv
// sample level types, shared by the front end and the buffer
package radio_pkg;

`include "radio_defs.svh"

   // one component of a complex sample, two's complement
   typedef logic [`IQ_W-1:0] iq_comp_t;

   // flat word as it sits in memory
   typedef logic [`SAMPLE_W-1:0] raw_word_t;

   // I in the upper half, Q in the lower half
   typedef struct packed {
      iq_comp_t i;
      iq_comp_t q;
   } iq_t;

   // same word seen two ways
   // raw for storage, iq for the correction math
   typedef union packed {
      raw_word_t raw;
      iq_t       iq;
   } sample_u;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build radio_top_tb with Verilator, run it, and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=radio_top_sim
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module radio_top_tb -f vlog.f -Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$build_dir/$sim_bin" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -F -q "*** PASSED ***" "$log"; then
   exit 0
else
   echo "pass line not found in $log"
   exit 1
fi

// File: rx_fe/rx_fe_corr.sv
`timescale 1ns/1ps

`include "radio_defs.svh"

// per-channel receive correction
// settings regs, optional I/Q swap, DC removal, one-deep hold toward the buffer
module rx_fe_corr #(
   parameter int CH_ID = 0
) (
   input  logic                radio_clk,
   input  logic                i_rst_n,
   input  bus_pkg::set_bus_t   i_set,
   input  radio_pkg::sample_u  i_rx,
   input  logic                i_rx_stb,
   input  logic                i_grant,
   output bus_pkg::wr_req_t    o_wr,
   output logic                o_overflow
);

   // channel select field of the settings address
   localparam logic [`SET_AW-`SR_REG_W-1:0] CH_SEL = (`SET_AW-`SR_REG_W)'(CH_ID);

   ////////////////////
   // settings registers
   ////////////////////
   logic                  set_hit;
   logic [`IQ_W-1:0]      dc_i_r;
   logic [`IQ_W-1:0]      dc_q_r;
   logic [1:0]            ctrl_r;  // {swap, run}
   logic                  run;
   logic                  swap;

   assign set_hit = i_set.stb && (i_set.addr[`SET_AW-1:`SR_REG_W] == CH_SEL);
   assign run     = ctrl_r[`CTRL_RUN_BIT];
   assign swap    = ctrl_r[`CTRL_SWAP_BIT];

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         dc_i_r <= '0;
         dc_q_r <= '0;
         ctrl_r <= '0;  // come up stopped, unswapped
      end else if (set_hit) begin
         case (i_set.addr[`SR_REG_W-1:0])
            `SR_DC_I: dc_i_r <= i_set.data[`IQ_W-1:0];
            `SR_DC_Q: dc_q_r <= i_set.data[`IQ_W-1:0];
            `SR_CTRL: ctrl_r <= i_set.data[1:0];
            default: ;  // unmapped offsets ignored
         endcase
      end
   end

   ////////////////////
   // swap and DC removal
   ////////////////////
   radio_pkg::sample_u rx_sw;   // after optional swap
   radio_pkg::sample_u rx_corr; // after offset subtract

   always_comb begin
      rx_sw = i_rx;
      if (swap) begin
         rx_sw.iq.i = i_rx.iq.q;
         rx_sw.iq.q = i_rx.iq.i;
      end
      // plain 16 bit subtract, wraps mod 2^16
      rx_corr.iq.i = rx_sw.iq.i - dc_i_r;
      rx_corr.iq.q = rx_sw.iq.q - dc_q_r;
   end

   ////////////////////
   // hold register and overflow
   ////////////////////
   logic               acc_stb;   // strobe seen while running
   logic               req_r;
   radio_pkg::sample_u sample_r;
   logic               ovf_r;

   assign acc_stb = i_rx_stb && run;

   // request level, set by an accepted strobe, cleared the edge after grant
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         req_r <= 1'b0;
      end else if (acc_stb && !req_r) begin
         req_r <= 1'b1;
      end else if (i_grant) begin
         req_r <= 1'b0;
      end
   end

   // payload only moves when the hold is free
   always_ff @(posedge radio_clk) begin
      if (acc_stb && !req_r) begin
         sample_r <= rx_corr;
      end
   end

   // a new sample while one still waits is dropped
   // flag is sticky until reset
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         ovf_r <= 1'b0;
      end else if (acc_stb && req_r) begin
         ovf_r <= 1'b1;
      end
   end

   assign o_wr.req    = req_r;
   assign o_wr.sample = sample_r;
   assign o_overflow  = ovf_r;

endmodule

// File: sample_buf/sample_buf.sv
`timescale 1ns/1ps

`include "radio_defs.svh"

// shared capture memory
// two channel writers and one readback port, round robin, one grant per cycle
module sample_buf (
   input  logic               radio_clk,
   input  logic               i_rst_n,
   input  bus_pkg::wr_req_t   i_wr0,
   input  bus_pkg::wr_req_t   i_wr1,
   output logic [`NUM_CH-1:0] o_grant,
   input  logic               i_rb_stb,
   input  logic [`BUF_AW:0]   i_rb_addr,  // top bit is the channel
   output bus_pkg::rb_rsp_t   o_rb
);

   localparam int NUM_REQ = `NUM_CH + 1;     // channels plus readback
   localparam int RB_IDX  = `NUM_CH;         // readback is the last requester
   localparam int DEPTH   = 2**(`BUF_AW+1);  // 64 words

   ////////////////////
   // readback pending
   ////////////////////
   logic             rb_pend_r;
   logic [`BUF_AW:0] rb_addr_r;
   logic [NUM_REQ-1:0] req;
   logic [NUM_REQ-1:0] gnt;

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         rb_pend_r <= 1'b0;
      end else if (i_rb_stb) begin
         rb_pend_r <= 1'b1;   // new strobe only when idle
      end else if (gnt[RB_IDX]) begin
         rb_pend_r <= 1'b0;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_rb_stb) begin
         rb_addr_r <= i_rb_addr;
      end
   end

   ////////////////////
   // round robin arbiter
   ////////////////////
   logic [1:0] last_r;  // index granted most recently

   assign req = {rb_pend_r, i_wr1.req, i_wr0.req};

   // search starts just after the last winner
   always_comb begin : rr_pick
      int idx;
      gnt = '0;
      for (int k = 1; k <= NUM_REQ; k++) begin
         idx = (int'(last_r) + k) % NUM_REQ;
         if (req[idx] && (gnt == '0)) begin
            gnt[idx] = 1'b1;
         end
      end
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         last_r <= 2'(RB_IDX);  // so ch0 is first in line
      end else begin
         case (gnt)
            3'b001:  last_r <= 2'd0;
            3'b010:  last_r <= 2'd1;
            3'b100:  last_r <= 2'(RB_IDX);
            default: ;  // idle keeps the order
         endcase
      end
   end

   assign o_grant = gnt[`NUM_CH-1:0];

   ////////////////////
   // write side
   ////////////////////
   logic [`BUF_AW-1:0]   wptr_r [`NUM_CH];
   logic                 wr_en;
   logic                 wr_ch;
   logic [`BUF_AW:0]     wr_addr;
   logic [`SAMPLE_W-1:0] wr_data;

   // at most one channel granted, so one write port is enough
   assign wr_en   = gnt[0] | gnt[1];
   assign wr_ch   = gnt[1];
   assign wr_addr = {wr_ch, wptr_r[wr_ch]};
   assign wr_data = wr_ch ? i_wr1.sample.raw : i_wr0.sample.raw;

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         for (int c = 0; c < `NUM_CH; c++) begin
            wptr_r[c] <= '0;
         end
      end else if (wr_en) begin
         wptr_r[wr_ch] <= wptr_r[wr_ch] + 1'b1;  // wraps at 32
      end
   end

   ////////////////////
   // memory and read data
   ////////////////////
   logic [`SAMPLE_W-1:0] mem [DEPTH];
   logic [`SAMPLE_W-1:0] rd_data_r;
   logic                 rb_valid_r;

   always_ff @(posedge radio_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      if (gnt[RB_IDX]) begin
         rd_data_r <= mem[rb_addr_r];  // read and write never share a cycle
      end
   end

   // one pulse per granted read
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         rb_valid_r <= 1'b0;
      end else begin
         rb_valid_r <= gnt[RB_IDX];
      end
   end

   assign o_rb.valid = rb_valid_r;
   assign o_rb.data  = rd_data_r;

endmodule

// File: verilog/radio_top.sv
`timescale 1ns/1ps

`include "radio_defs.svh"

// two channel receive front end with shared capture buffer
module radio_top (
   input  logic               radio_clk,
   input  logic               i_rst_n,
   input  bus_pkg::set_bus_t  i_set,      // shared by both channels
   input  radio_pkg::sample_u i_rx0,
   input  logic               i_rx_stb0,
   input  radio_pkg::sample_u i_rx1,
   input  logic               i_rx_stb1,
   input  logic               i_rb_stb,
   input  logic [`BUF_AW:0]   i_rb_addr,
   output bus_pkg::rb_rsp_t   o_rb,
   output logic [`NUM_CH-1:0] o_overflow
);

   bus_pkg::wr_req_t   wr0;    // ch0 to buffer
   bus_pkg::wr_req_t   wr1;    // ch1 to buffer
   logic [`NUM_CH-1:0] grant;

   ////////////////////
   // front end correction
   rx_fe_corr #(.CH_ID(0)) ch0_i (
      .radio_clk  (radio_clk),
      .i_rst_n    (i_rst_n),
      .i_set      (i_set),
      .i_rx       (i_rx0),
      .i_rx_stb   (i_rx_stb0),
      .i_grant    (grant[0]),
      .o_wr       (wr0),
      .o_overflow (o_overflow[0])
   );

   rx_fe_corr #(.CH_ID(1)) ch1_i (
      .radio_clk  (radio_clk),
      .i_rst_n    (i_rst_n),
      .i_set      (i_set),
      .i_rx       (i_rx1),
      .i_rx_stb   (i_rx_stb1),
      .i_grant    (grant[1]),
      .o_wr       (wr1),
      .o_overflow (o_overflow[1])
   );

   ////////////////////
   // capture buffer
   sample_buf buf_i (
      .radio_clk (radio_clk),
      .i_rst_n   (i_rst_n),
      .i_wr0     (wr0),
      .i_wr1     (wr1),
      .o_grant   (grant),
      .i_rb_stb  (i_rb_stb),
      .i_rb_addr (i_rb_addr),
      .o_rb      (o_rb)
   );

endmodule

// File: vlog.f
+incdir+common
common/radio_pkg.sv
common/bus_pkg.sv
rx_fe/rx_fe_corr.sv
sample_buf/sample_buf.sv
verilog/radio_top.sv
bench/radio_top_assert.sv
bench/radio_top_tb.sv
